// File: common/traffic_gen_pkg.sv
package traffic_gen_pkg;

    // widths of the unified cache interface
    parameter int ADDR_WIDTH        = 32;
    parameter int BLOCK_WIDTH       = 128;
    parameter int BYTE_MASK_WIDTH   = 16;
    parameter int PORT_ID_WIDTH     = 2;
    parameter int PKT_TYPE_WIDTH    = 2;
    parameter int BLOCK_OFFSET_BITS = 4;

    // test data is one 32-bit index repeated across the block
    parameter int WORD_WIDTH        = 32;
    parameter int WORDS_PER_BLOCK   = BLOCK_WIDTH / WORD_WIDTH;

    parameter logic [ADDR_WIDTH-1:0]    BASE_ADDR     = 32'h0000_1000;
    parameter logic [PORT_ID_WIDTH-1:0] WRITE_PORT_ID = 2'd0;
    parameter logic [PORT_ID_WIDTH-1:0] READ_PORT_ID  = 2'd1;

    // packet field positions, bit 0 upward
    parameter int ADDR_LO       = 0;
    parameter int DATA_LO       = ADDR_LO + ADDR_WIDTH;
    parameter int MASK_LO       = DATA_LO + BLOCK_WIDTH;
    parameter int PORT_LO       = MASK_LO + BYTE_MASK_WIDTH;
    parameter int TYPE_LO       = PORT_LO + PORT_ID_WIDTH;
    parameter int VALID_POS     = TYPE_LO + PKT_TYPE_WIDTH;
    parameter int IS_WRITE_POS  = VALID_POS + 1;
    parameter int CACHEABLE_POS = IS_WRITE_POS + 1;
    parameter int PACKET_WIDTH  = CACHEABLE_POS + 1;

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [BLOCK_WIDTH-1:0]     block_t;
    typedef logic [BYTE_MASK_WIDTH-1:0] byte_mask_t;
    typedef logic [PORT_ID_WIDTH-1:0]   port_id_t;
    typedef logic [PKT_TYPE_WIDTH-1:0]  pkt_type_t;
    typedef logic [PACKET_WIDTH-1:0]    packet_t;
    typedef logic [WORD_WIDTH-1:0]      word_t;

    // request and return index
    typedef logic [15:0]                count_t;

    // cycle counter for the timeouts
    typedef logic [31:0]                timeout_t;

    typedef enum logic [1:0]
    {
        PHASE_WRITE,
        PHASE_READ,
        PHASE_FINISH,
        PHASE_FAIL
    } phase_t;

endpackage

// File: request_issuer/request_issuer.sv
`timescale 1ns/10ps

module request_issuer
#(
    parameter int NUM_REQUEST    = 16,
    parameter int TIMEOUT_CYCLES = 100000,
    parameter bit IS_WRITE       = 1'b1
)
(
    input  logic                     clk_in,
    input  logic                     reset_in,
    input  logic                     enable,
    input  logic                     ack,
    output traffic_gen_pkg::packet_t packet,
    output logic                     issue_done,
    output logic                     ack_timeout
);

    localparam traffic_gen_pkg::count_t   LAST_INDEX   =
        traffic_gen_pkg::count_t'(NUM_REQUEST - 1);
    localparam traffic_gen_pkg::timeout_t TIMEOUT_LAST =
        traffic_gen_pkg::timeout_t'(TIMEOUT_CYCLES - 1);

    logic                       enable_q;
    traffic_gen_pkg::count_t    req_index;
    traffic_gen_pkg::timeout_t  wait_count;
    traffic_gen_pkg::packet_t   packet_q;
    traffic_gen_pkg::packet_t   next_packet;
    traffic_gen_pkg::addr_t     req_addr;
    traffic_gen_pkg::word_t     req_word;
    logic                       pkt_valid;

    assign pkt_valid = packet_q[traffic_gen_pkg::VALID_POS];
    assign packet    = packet_q;

    // block address and data word follow the request index
    assign req_addr = traffic_gen_pkg::BASE_ADDR +
                      (traffic_gen_pkg::addr_t'(req_index) << traffic_gen_pkg::BLOCK_OFFSET_BITS);
    assign req_word = traffic_gen_pkg::word_t'(req_index);

    always_comb
    begin
        next_packet = '0;
        next_packet[traffic_gen_pkg::ADDR_LO +: traffic_gen_pkg::ADDR_WIDTH] = req_addr;
        next_packet[traffic_gen_pkg::TYPE_LO +: traffic_gen_pkg::PKT_TYPE_WIDTH] =
            traffic_gen_pkg::pkt_type_t'(0);
        next_packet[traffic_gen_pkg::VALID_POS]     = 1'b1;
        next_packet[traffic_gen_pkg::IS_WRITE_POS]  = IS_WRITE;
        next_packet[traffic_gen_pkg::CACHEABLE_POS] = 1'b1;
        if (IS_WRITE)
        begin
            next_packet[traffic_gen_pkg::DATA_LO +: traffic_gen_pkg::BLOCK_WIDTH] =
                {traffic_gen_pkg::WORDS_PER_BLOCK{req_word}};
            next_packet[traffic_gen_pkg::MASK_LO +: traffic_gen_pkg::BYTE_MASK_WIDTH] =
                traffic_gen_pkg::byte_mask_t'('1);
            next_packet[traffic_gen_pkg::PORT_LO +: traffic_gen_pkg::PORT_ID_WIDTH] =
                traffic_gen_pkg::WRITE_PORT_ID;
        end
        else
        begin
            // reads carry no data and no mask
            next_packet[traffic_gen_pkg::PORT_LO +: traffic_gen_pkg::PORT_ID_WIDTH] =
                traffic_gen_pkg::READ_PORT_ID;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            enable_q    <= 1'b0;
            req_index   <= '0;
            wait_count  <= '0;
            packet_q    <= '0;
            issue_done  <= 1'b0;
            ack_timeout <= 1'b0;
        end
        else
        begin
            enable_q <= enable;

            if (pkt_valid && ack)
            begin
                // retire, next request loads one cycle later
                packet_q   <= '0;
                req_index  <= req_index + 1'b1;
                wait_count <= '0;
                if (req_index == LAST_INDEX)
                begin
                    issue_done <= 1'b1;
                end
            end
            else if (pkt_valid)
            begin
                // held without ack
                if (!ack_timeout)
                begin
                    wait_count <= wait_count + 1'b1;
                end
                if (wait_count == TIMEOUT_LAST)
                begin
                    ack_timeout <= 1'b1;
                end
            end
            else if (enable_q && !issue_done)
            begin
                packet_q <= next_packet;
            end
        end
    end

endmodule

// File: design/return_checker.sv
`timescale 1ns/10ps

module return_checker
#(
    parameter int NUM_REQUEST    = 16,
    parameter int TIMEOUT_CYCLES = 100000
)
(
    input  logic                     clk_in,
    input  logic                     reset_in,
    input  logic                     armed,
    input  traffic_gen_pkg::packet_t return_packet,
    output logic                     return_ack,
    output logic                     returns_done,
    output logic                     data_mismatch,
    output logic                     return_timeout
);

    localparam traffic_gen_pkg::count_t     LAST_INDEX   =
        traffic_gen_pkg::count_t'(NUM_REQUEST - 1);
    localparam traffic_gen_pkg::timeout_t   TIMEOUT_LAST =
        traffic_gen_pkg::timeout_t'(TIMEOUT_CYCLES - 1);

    traffic_gen_pkg::count_t    expected_index;
    traffic_gen_pkg::timeout_t  idle_count;
    traffic_gen_pkg::block_t    return_block;
    traffic_gen_pkg::block_t    expected_block;
    logic                       return_valid;
    logic                       block_differs;
    logic                       outstanding;

    assign return_valid   = return_packet[traffic_gen_pkg::VALID_POS];
    assign return_block   =
        return_packet[traffic_gen_pkg::DATA_LO +: traffic_gen_pkg::BLOCK_WIDTH];
    assign expected_block =
        {traffic_gen_pkg::WORDS_PER_BLOCK{traffic_gen_pkg::word_t'(expected_index)}};

    // every byte was written, so the whole block is compared
    assign block_differs  = return_block != expected_block;

    // timer only runs while reads are owed a return
    assign outstanding = armed && !returns_done;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            expected_index <= '0;
            idle_count     <= '0;
            return_ack     <= 1'b0;
            returns_done   <= 1'b0;
            data_mismatch  <= 1'b0;
            return_timeout <= 1'b0;
        end
        else
        begin
            return_ack <= return_valid;

            if (return_valid)
            begin
                expected_index <= expected_index + 1'b1;
                idle_count     <= '0;
                if (block_differs)
                begin
                    data_mismatch <= 1'b1;
                end
                if (expected_index == LAST_INDEX)
                begin
                    returns_done <= 1'b1;
                end
            end
            else if (outstanding && !return_timeout)
            begin
                idle_count <= idle_count + 1'b1;
                if (idle_count == TIMEOUT_LAST)
                begin
                    return_timeout <= 1'b1;
                end
            end
        end
    end

endmodule

// File: design/run_sequencer.sv
`timescale 1ns/10ps

module run_sequencer
(
    input  logic clk_in,
    input  logic reset_in,

    input  logic write_done,
    input  logic read_done,
    input  logic returns_done,

    input  logic write_timeout,
    input  logic read_timeout,
    input  logic return_timeout,
    input  logic data_mismatch,

    output logic read_start,
    output logic done,
    output logic error
);

    traffic_gen_pkg::phase_t phase_q;
    traffic_gen_pkg::phase_t phase_next;
    logic                    failure;

    assign failure = write_timeout || read_timeout || return_timeout || data_mismatch;

    always_comb
    begin
        phase_next = phase_q;
        case (phase_q)
            traffic_gen_pkg::PHASE_WRITE:
            begin
                if (failure)
                begin
                    phase_next = traffic_gen_pkg::PHASE_FAIL;
                end
                else if (write_done)
                begin
                    phase_next = traffic_gen_pkg::PHASE_READ;
                end
            end

            traffic_gen_pkg::PHASE_READ:
            begin
                if (failure)
                begin
                    phase_next = traffic_gen_pkg::PHASE_FAIL;
                end
                else if (read_done && returns_done)
                begin
                    phase_next = traffic_gen_pkg::PHASE_FINISH;
                end
            end

            // finish and fail hold until reset
            default:
            begin
                phase_next = phase_q;
            end
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            phase_q <= traffic_gen_pkg::PHASE_WRITE;
        end
        else
        begin
            phase_q <= phase_next;
        end
    end

    // a failed write phase never opens the read port
    assign read_start = (phase_q != traffic_gen_pkg::PHASE_WRITE) && write_done;
    assign done       = (phase_q == traffic_gen_pkg::PHASE_FINISH);
    assign error      = (phase_q == traffic_gen_pkg::PHASE_FAIL);

endmodule

// File: design/traffic_gen_top.sv
`timescale 1ns/10ps

module traffic_gen_top
#(
    parameter int NUM_REQUEST    = 16,
    parameter int TIMEOUT_CYCLES = 100000
)
(
    input  logic                     clk_in,
    input  logic                     reset_in,

    output traffic_gen_pkg::packet_t write_packet,
    input  logic                     write_ack,

    output traffic_gen_pkg::packet_t read_packet,
    input  logic                     read_ack,

    input  traffic_gen_pkg::packet_t return_packet,
    output logic                     return_ack,

    output logic                     done,
    output logic                     error
);

    logic write_done;
    logic write_timeout;
    logic read_done;
    logic read_timeout;
    logic read_start;
    logic returns_done;
    logic data_mismatch;
    logic return_timeout;

    // write stream runs right after reset
    request_issuer
    #(
        .NUM_REQUEST    (NUM_REQUEST),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .IS_WRITE       (1'b1)
    )
    u_write_issuer
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .enable         (1'b1),
        .ack            (write_ack),
        .packet         (write_packet),
        .issue_done     (write_done),
        .ack_timeout    (write_timeout)
    );

    // read stream waits for the sequencer
    request_issuer
    #(
        .NUM_REQUEST    (NUM_REQUEST),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .IS_WRITE       (1'b0)
    )
    u_read_issuer
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .enable         (read_start),
        .ack            (read_ack),
        .packet         (read_packet),
        .issue_done     (read_done),
        .ack_timeout    (read_timeout)
    );

    return_checker
    #(
        .NUM_REQUEST    (NUM_REQUEST),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    )
    u_return_checker
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .armed          (read_start),
        .return_packet  (return_packet),
        .return_ack     (return_ack),
        .returns_done   (returns_done),
        .data_mismatch  (data_mismatch),
        .return_timeout (return_timeout)
    );

    run_sequencer u_run_sequencer
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .write_done     (write_done),
        .read_done      (read_done),
        .returns_done   (returns_done),
        .write_timeout  (write_timeout),
        .read_timeout   (read_timeout),
        .return_timeout (return_timeout),
        .data_mismatch  (data_mismatch),
        .read_start     (read_start),
        .done           (done),
        .error          (error)
    );

endmodule

// File: tests/traffic_gen_sva.sv
`timescale 1ns/10ps

module traffic_gen_sva
(
    input logic                     clk_in,
    input logic                     reset_in,
    input traffic_gen_pkg::packet_t write_packet,
    input logic                     write_ack,
    input traffic_gen_pkg::packet_t read_packet,
    input logic                     read_ack,
    input traffic_gen_pkg::packet_t return_packet,
    input logic                     return_ack,
    input logic                     done,
    input logic                     error
);

    localparam int VALID_POS = traffic_gen_pkg::VALID_POS;

    // failures seen so far, read by the testbench
    int assert_errors = 0;

    done_error_exclusive: assert property (@(posedge clk_in) disable iff (reset_in)
        !(done && error))
        else begin $error("done and error high together"); assert_errors++; end

    write_held: assert property (@(posedge clk_in) disable iff (reset_in)
        write_packet[VALID_POS] && !write_ack |=> $stable(write_packet))
        else begin $error("write request changed before ack"); assert_errors++; end

    read_held: assert property (@(posedge clk_in) disable iff (reset_in)
        read_packet[VALID_POS] && !read_ack |=> $stable(read_packet))
        else begin $error("read request changed before ack"); assert_errors++; end

    return_ack_follows: assert property (@(posedge clk_in) disable iff (reset_in)
        return_packet[VALID_POS] |=> return_ack)
        else begin $error("return_ack missing after return"); assert_errors++; end

    return_ack_only_after: assert property (@(posedge clk_in) disable iff (reset_in)
        !return_packet[VALID_POS] |=> !return_ack)
        else begin $error("return_ack without a return"); assert_errors++; end

    done_sticky: assert property (@(posedge clk_in) disable iff (reset_in) done |=> done)
        else begin $error("done dropped before reset"); assert_errors++; end

    error_sticky: assert property (@(posedge clk_in) disable iff (reset_in) error |=> error)
        else begin $error("error dropped before reset"); assert_errors++; end

endmodule

bind traffic_gen_top traffic_gen_sva u_sva (.*);

// File: tests/traffic_gen_tb.sv
`timescale 1ns/10ps

module traffic_gen_tb;

    localparam int NUM_REQUEST    = 16;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int FIELDS         = 8;
    localparam int MAX_TESTS      = 16;
    localparam int VALID_POS      = traffic_gen_pkg::VALID_POS;
    localparam int ADDR_LO        = traffic_gen_pkg::ADDR_LO;
    localparam int DATA_LO        = traffic_gen_pkg::DATA_LO;
    localparam int MASK_LO        = traffic_gen_pkg::MASK_LO;
    localparam int PORT_LO        = traffic_gen_pkg::PORT_LO;
    localparam int IS_WRITE_POS   = traffic_gen_pkg::IS_WRITE_POS;
    localparam int CACHEABLE_POS  = traffic_gen_pkg::CACHEABLE_POS;

    logic                     clk_in;
    logic                     reset_in;
    traffic_gen_pkg::packet_t write_packet;
    logic                     write_ack;
    traffic_gen_pkg::packet_t read_packet;
    logic                     read_ack;
    traffic_gen_pkg::packet_t return_packet;
    logic                     return_ack;
    logic                     done;
    logic                     error;

    logic [31:0] golden [0:FIELDS*MAX_TESTS-1];
    int          cfg_wr_max;
    int          cfg_rd_max;
    int          cfg_ret_max;
    int          cfg_fault;
    int          cfg_k;
    logic        exp_done;
    logic        exp_error;
    int          wr_count;
    int          rd_count;
    int          ret_count;
    int          wr_wait;
    int          rd_wait;
    int          ret_wait;
    int          wr_target;
    int          rd_target;
    int          ret_target;
    logic [15:0] wr_lfsr;
    logic [15:0] rd_lfsr;
    logic [15:0] ret_lfsr;
    int          err_count;
    int          pass_count;
    int          fail_count;
    int          num_tests;
    int          watch_limit;

    // cache model contents and reads still owed a return
    traffic_gen_pkg::block_t cache_mem [traffic_gen_pkg::addr_t];
    traffic_gen_pkg::addr_t  return_q [$];

    traffic_gen_top
    #(
        .NUM_REQUEST    (NUM_REQUEST),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    )
    DUT
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .write_packet   (write_packet),
        .write_ack      (write_ack),
        .read_packet    (read_packet),
        .read_ack       (read_ack),
        .return_packet  (return_packet),
        .return_ack     (return_ack),
        .done           (done),
        .error          (error)
    );

    always #20 clk_in = ~clk_in;

    // x^16 + x^14 + x^13 + x^11 + 1, four steps leave four new low bits
    function automatic logic [15:0] lfsr_next4(input logic [15:0] state);
        logic [15:0] s;
        s = state;
        for (int i = 0; i < 4; i++)
        begin
            s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        end
        return s;
    endfunction

    function automatic int pick_delay(input logic [15:0] state, input int max_delay);
        logic [15:0] s;
        s = lfsr_next4(state);
        return int'(s[3:0]) % (max_delay + 1);
    endfunction

    function automatic traffic_gen_pkg::addr_t expected_addr(input int index);
        return traffic_gen_pkg::BASE_ADDR + (32'(index) << traffic_gen_pkg::BLOCK_OFFSET_BITS);
    endfunction

    function automatic traffic_gen_pkg::block_t expected_block(input int index);
        return {4{32'(index)}};
    endfunction

    function automatic int test_cycles(input int max_delay);
        return 4 * NUM_REQUEST * (max_delay + 4) + TIMEOUT_CYCLES + 100;
    endfunction

    // the cache's answer to a read, one data bit flipped when corrupt
    function automatic traffic_gen_pkg::packet_t return_for(input traffic_gen_pkg::addr_t addr,
                                                            input logic corrupt);
        traffic_gen_pkg::packet_t pkt;
        traffic_gen_pkg::block_t  block;
        pkt   = '0;
        block = cache_mem.exists(addr) ? cache_mem[addr] : '0;
        if (corrupt)
            block[0] = ~block[0];
        pkt[ADDR_LO +: 32]  = addr;
        pkt[DATA_LO +: 128] = block;
        pkt[PORT_LO +: 2]   = traffic_gen_pkg::READ_PORT_ID;
        pkt[VALID_POS]      = 1'b1;
        return pkt;
    endfunction

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual)
        begin
            $display("ERR at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    // write port of the cache model
    always @(posedge clk_in)
    begin
        if (reset_in)
        begin
            write_ack <= 1'b0;
            wr_count  <= 0;
            wr_wait   <= 0;
            wr_target <= pick_delay(wr_lfsr, cfg_wr_max);
            wr_lfsr   <= lfsr_next4(wr_lfsr);
            cache_mem.delete();
        end
        else if (write_packet[VALID_POS] && write_ack)
        begin
            check_value("write_packet.addr", expected_addr(wr_count), write_packet[ADDR_LO +: 32]);
            check_value("write_packet.data", expected_block(wr_count),
                        write_packet[DATA_LO +: 128]);
            check_value("write_packet.mask", 16'hffff, write_packet[MASK_LO +: 16]);
            check_value("write_packet.port", traffic_gen_pkg::WRITE_PORT_ID,
                        write_packet[PORT_LO +: 2]);
            check_value("write_packet.is_write", 1'b1, write_packet[IS_WRITE_POS]);
            check_value("write_packet.cacheable", 1'b1, write_packet[CACHEABLE_POS]);
            cache_mem[write_packet[ADDR_LO +: 32]] = write_packet[DATA_LO +: 128];
            write_ack <= 1'b0;
            wr_count  <= wr_count + 1;
            wr_target <= pick_delay(wr_lfsr, cfg_wr_max);
            wr_lfsr   <= lfsr_next4(wr_lfsr);
        end
        else if (write_packet[VALID_POS] && cfg_fault != 2)
        begin
            if (wr_wait >= wr_target)
            begin
                write_ack <= 1'b1;
                wr_wait   <= 0;
            end
            else
            begin
                wr_wait <= wr_wait + 1;
            end
        end
    end

    // read port and return path, returns go out as one-cycle pulses in order
    always @(posedge clk_in)
    begin
        if (reset_in)
        begin
            read_ack      <= 1'b0;
            return_packet <= '0;
            rd_count      <= 0;
            ret_count     <= 0;
            rd_wait       <= 0;
            ret_wait      <= 0;
            rd_target     <= pick_delay(rd_lfsr, cfg_rd_max);
            rd_lfsr       <= lfsr_next4(rd_lfsr);
            ret_target    <= pick_delay(ret_lfsr, cfg_ret_max);
            ret_lfsr      <= lfsr_next4(ret_lfsr);
            return_q.delete();
        end
        else
        begin
            if (return_packet[VALID_POS])
            begin
                return_packet <= '0;
            end
            else if (return_q.size() > 0 && cfg_fault != 3)
            begin
                if (ret_wait >= ret_target)
                begin
                    return_packet <= return_for(return_q.pop_front(),
                                                cfg_fault == 1 && ret_count == cfg_k);
                    ret_count  <= ret_count + 1;
                    ret_wait   <= 0;
                    ret_target <= pick_delay(ret_lfsr, cfg_ret_max);
                    ret_lfsr   <= lfsr_next4(ret_lfsr);
                end
                else
                begin
                    ret_wait <= ret_wait + 1;
                end
            end

            if (read_packet[VALID_POS])
            begin
                check_value("writes acked before read", NUM_REQUEST, wr_count);
            end
            if (read_packet[VALID_POS] && read_ack)
            begin
                check_value("read_packet.addr", expected_addr(rd_count), read_packet[ADDR_LO +: 32]);
                check_value("read_packet.port", traffic_gen_pkg::READ_PORT_ID,
                            read_packet[PORT_LO +: 2]);
                check_value("read_packet.is_write", 1'b0, read_packet[IS_WRITE_POS]);
                return_q.push_back(read_packet[ADDR_LO +: 32]);
                read_ack  <= 1'b0;
                rd_count  <= rd_count + 1;
                rd_target <= pick_delay(rd_lfsr, cfg_rd_max);
                rd_lfsr   <= lfsr_next4(rd_lfsr);
            end
            else if (read_packet[VALID_POS])
            begin
                if (rd_wait >= rd_target)
                begin
                    read_ack <= 1'b1;
                    rd_wait  <= 0;
                end
                else
                begin
                    rd_wait <= rd_wait + 1;
                end
            end
        end
    end

    task automatic run_test(input int t);
        int base;
        int limit;
        int cycles;
        int errors_before;
        base          = t * FIELDS;
        errors_before = err_count;
        @(posedge clk_in);
        reset_in <= 1'b1;
        @(posedge clk_in);
        cfg_wr_max  = golden[base + 1];
        cfg_rd_max  = golden[base + 2];
        cfg_ret_max = golden[base + 3];
        cfg_fault   = golden[base + 4];
        cfg_k       = golden[base + 5];
        exp_done    = golden[base + 6][0];
        exp_error   = golden[base + 7][0];
        limit = test_cycles(cfg_wr_max > cfg_rd_max ?
                            (cfg_wr_max > cfg_ret_max ? cfg_wr_max : cfg_ret_max) :
                            (cfg_rd_max > cfg_ret_max ? cfg_rd_max : cfg_ret_max));
        repeat (15) @(posedge clk_in);
        reset_in <= 1'b0;
        cycles = 0;
        while (!done && !error && cycles < limit)
        begin
            @(posedge clk_in);
            cycles++;
        end
        if (!done && !error)
        begin
            $display("test %0h: neither done nor error within %0d cycles", golden[base], limit);
            err_count++;
        end
        // extra cycles so that a late done after an error shows up
        repeat (8) @(posedge clk_in);
        check_value("done", exp_done, done);
        check_value("error", exp_error, error);
        if (cfg_fault == 0)
        begin
            check_value("write count", NUM_REQUEST, wr_count);
            check_value("read count", NUM_REQUEST, rd_count);
            check_value("return count", NUM_REQUEST, ret_count);
        end
        if (cfg_fault == 2)
            check_value("read count", 0, rd_count);
        if (cfg_fault == 3)
            check_value("reads acked", 1'b1, rd_count > 0);
        if (err_count == errors_before)
            pass_count++;
        else
            fail_count++;
        $display("test %0h %s: fault %0d, %0d writes, %0d reads, %0d returns, done %0b error %0b",
                 golden[base], (err_count == errors_before) ? "ok" : "wrong", cfg_fault,
                 wr_count, rd_count, ret_count, done, error);
    endtask

    initial
    begin : main
        int gmax;
        clk_in        = 1'b0;
        reset_in      = 1'b1;
        write_ack     = 1'b0;
        read_ack      = 1'b0;
        return_packet = '0;
        wr_lfsr       = 16'd93;
        rd_lfsr       = 16'd93;
        ret_lfsr      = 16'd93;
        gmax          = 0;
        for (int i = 0; i < FIELDS * MAX_TESTS; i++)
            golden[i] = '1;
        $readmemh("tests/traffic_gen_golden.txt", golden);
        while (num_tests < MAX_TESTS && golden[num_tests * FIELDS] !== '1)
        begin
            for (int f = 1; f <= 3; f++)
                if (golden[num_tests * FIELDS + f] > gmax)
                    gmax = golden[num_tests * FIELDS + f];
            num_tests++;
        end
        if (num_tests == 0)
        begin
            $display("golden file holds no tests");
            err_count++;
        end
        watch_limit = num_tests * (test_cycles(gmax) + 26);
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        $display("tests %0d, ok %0d, wrong %0d, check errors %0d, assertion errors %0d",
                 num_tests, pass_count, fail_count, err_count, DUT.u_sva.assert_errors);
        if (err_count == 0 && fail_count == 0 && DUT.u_sva.assert_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // watchdog over the whole run
    initial
    begin
        wait (watch_limit > 0);
        repeat (watch_limit) @(posedge clk_in);
        $display("watchdog: run did not end within %0d cycles", watch_limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: traffic_gen.f
common/traffic_gen_pkg.sv
request_issuer/request_issuer.sv
design/return_checker.sv
design/run_sequencer.sv
design/traffic_gen_top.sv
tests/traffic_gen_sva.sv
tests/traffic_gen_tb.sv

// File: tests/traffic_gen_golden.txt
// one test per line, hex fields: id, max write ack delay, max read ack delay, max return delay,
// fault (0 none, 1 corrupt return k, 2 withhold write ack, 3 withhold returns), k, done, error
01 0 0 0 0 0 1 0
02 3 3 7 0 0 1 0
03 2 1 3 1 5 0 1
04 0 0 0 2 0 0 1
05 1 2 2 3 0 0 1
